/* logic/riscv_types.sv */
// Shared types for the RV32I execution pipeline that every stage and the top level import
package riscv_types;

  // Data word and pc value
  typedef logic [31:0] word_t;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // ALU operation with funct3 in the low bits and funct7[5] in bit 3
  typedef enum logic [3:0] {
    ADD,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    OR,
    AND,
    SUB = 4'b1000,
    SRA = 4'b1101
  } alu_t;

  // Major opcodes handled here
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_t;

  // Decode to execute
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rdata1;
    word_t     rdata2;
    word_t     imm;
    alu_t      alu_op;
    // Operand selects
    logic      alu_src;
    logic      op1_pc;
    logic      op1_zero;
    // Control
    logic      reg_write;
    logic      illegal;
  } id_exe_reg_t;

  // Execute to result
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    word_t     result;
    logic      reg_write;
    logic      illegal;
  } exe_wb_reg_t;

endpackage

/* logic/reg_file.sv */
// Integer register file of the pipeline that decode reads and the result stage writes
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk,
  input  logic                  reset_n,
  input  riscv_types::reg_addr_t raddr1,
  input  riscv_types::reg_addr_t raddr2,
  output riscv_types::word_t    rdata1,
  output riscv_types::word_t    rdata2,
  input  logic                  wen,
  input  riscv_types::reg_addr_t waddr,
  input  riscv_types::word_t    wdata
);
  import riscv_types::*;

  // x0 has no storage
  word_t regs [1:31];

  function automatic word_t read_port(input reg_addr_t addr);
    word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wen && (waddr == addr)) begin
      // Write-through for a read in the same cycle
      value = wdata;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

endmodule : reg_file

/* logic/inst_decode.sv */
// Decode stage that reads the register file and fills the decode/execute register
`timescale 1ns/1ps

module inst_decode (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     inst_valid,
  input  riscv_types::word_t       inst,
  input  riscv_types::word_t       pc,
  output riscv_types::reg_addr_t   raddr1,
  output riscv_types::reg_addr_t   raddr2,
  input  riscv_types::word_t       rdata1,
  input  riscv_types::word_t       rdata2,
  output riscv_types::id_exe_reg_t id_exe
);
  import riscv_types::*;

  opcode_t     opcode;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  word_t       imm_i;
  word_t       imm_u;
  logic        legal;
  id_exe_reg_t id_next;

  assign opcode = opcode_t'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};

  assign raddr1 = rs1;
  assign raddr2 = rs2;

  always_comb begin
    id_next        = '0;
    id_next.valid  = inst_valid;
    id_next.pc     = pc;
    id_next.rs1    = rs1;
    id_next.rs2    = rs2;
    id_next.rd     = rd;
    id_next.rdata1 = rdata1;
    id_next.rdata2 = rdata2;
    id_next.imm    = imm_i;
    id_next.alu_op = ADD;
    legal          = 1'b1;
    case (opcode)
      OPC_OP: begin
        id_next.alu_op = alu_t'({funct7[5], funct3});
        // funct7[5] only for SUB and SRA
        legal = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      OPC_OP_IMM: begin
        id_next.alu_src = 1'b1;
        if (funct3 == 3'b101) begin
          id_next.alu_op = alu_t'({funct7[5], funct3});
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          id_next.alu_op = alu_t'({1'b0, funct3});
          legal = (funct3 != 3'b001) || (funct7 == 7'b0000000);
        end
      end
      OPC_LUI: begin
        id_next.imm      = imm_u;
        id_next.alu_src  = 1'b1;
        id_next.op1_zero = 1'b1;
      end
      OPC_AUIPC: begin
        id_next.imm     = imm_u;
        id_next.alu_src = 1'b1;
        id_next.op1_pc  = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    id_next.illegal   = ~legal;
    id_next.reg_write = legal && (rd != '0);
  end

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      id_exe <= '0;
    end else begin
      id_exe <= id_next;
    end
  end

endmodule : inst_decode

/* logic/alu_execute.sv */
// Execute stage that forwards operands, runs the ALU and fills the execute/result register
`timescale 1ns/1ps

module alu_execute (
  input  logic                     clk,
  input  logic                     reset_n,
  input  riscv_types::id_exe_reg_t id_exe,
  input  logic                     wen,
  input  riscv_types::reg_addr_t   waddr,
  input  riscv_types::word_t       wdata,
  output riscv_types::exe_wb_reg_t exe_wb
);
  import riscv_types::*;

  word_t       fwd1;
  word_t       fwd2;
  word_t       op1;
  word_t       op2;
  word_t       result;
  logic [4:0]  shamt;
  logic [1:0]  op1_sel;
  exe_wb_reg_t exe_next;

  // Newest producer wins and x0 is never forwarded
  function automatic word_t forward(input reg_addr_t rs, input word_t rdata);
    word_t value;
    if ((rs != '0) && exe_wb.valid && exe_wb.reg_write && (exe_wb.rd == rs)) begin
      value = exe_wb.result;
    end else if ((rs != '0) && wen && (waddr == rs)) begin
      value = wdata;
    end else begin
      value = rdata;
    end
    return value;
  endfunction

  always_comb begin
    fwd1 = forward(id_exe.rs1, id_exe.rdata1);
    fwd2 = forward(id_exe.rs2, id_exe.rdata2);
  end

  // One-hot operand 1 where LUI leaves both selects low
  assign op1_sel = {id_exe.op1_pc, ~(id_exe.op1_pc | id_exe.op1_zero)};
  assign op1     = (fwd1 & {32{op1_sel[0]}}) | (id_exe.pc & {32{op1_sel[1]}});
  assign op2     = id_exe.alu_src ? id_exe.imm : fwd2;
  assign shamt   = op2[4:0];

  always_comb begin
    case (id_exe.alu_op)
      ADD:     result = op1 + op2;
      SUB:     result = op1 - op2;
      SLL:     result = op1 << shamt;
      SLT:     result = {31'b0, $signed(op1) < $signed(op2)};
      SLTU:    result = {31'b0, op1 < op2};
      XOR:     result = op1 ^ op2;
      SRL:     result = op1 >> shamt;
      SRA:     result = $signed(op1) >>> shamt;
      OR:      result = op1 | op2;
      AND:     result = op1 & op2;
      default: result = '0;
    endcase
  end

  always_comb begin
    exe_next.valid     = id_exe.valid;
    exe_next.pc        = id_exe.pc;
    exe_next.rd        = id_exe.rd;
    exe_next.result    = result;
    exe_next.reg_write = id_exe.reg_write;
    exe_next.illegal   = id_exe.illegal;
  end

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      exe_wb <= '0;
    end else begin
      exe_wb <= exe_next;
    end
  end

endmodule : alu_execute

/* logic/result_stage.sv */
// Result stage that turns the execute/result register into the register write and retire port
`timescale 1ns/1ps

module result_stage (
  input  riscv_types::exe_wb_reg_t exe_wb,
  output logic                     wen,
  output riscv_types::reg_addr_t   waddr,
  output riscv_types::word_t       wdata,
  output logic                     retire_valid,
  output riscv_types::word_t       retire_pc,
  output riscv_types::reg_addr_t   retire_rd,
  output riscv_types::word_t       retire_data,
  output logic                     retire_illegal
);

  // Only legal, retiring instructions write
  assign wen   = exe_wb.valid & exe_wb.reg_write & ~exe_wb.illegal;
  assign waddr = exe_wb.rd;
  assign wdata = exe_wb.result;

  assign retire_valid   = exe_wb.valid;
  assign retire_pc      = exe_wb.pc;
  assign retire_rd      = exe_wb.rd;
  assign retire_data    = exe_wb.illegal ? '0 : exe_wb.result;
  assign retire_illegal = exe_wb.illegal;

endmodule : result_stage

/* logic/alu_core_top.sv */
// Top of the RV32I execution pipeline that takes the instruction strobe and drives the retire port
`timescale 1ns/1ps

module alu_core_top (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   inst_valid,
  input  riscv_types::word_t     inst,
  input  riscv_types::word_t     pc,
  output logic                   retire_valid,
  output riscv_types::word_t     retire_pc,
  output riscv_types::reg_addr_t retire_rd,
  output riscv_types::word_t     retire_data,
  output logic                   retire_illegal
);
  import riscv_types::*;

  reg_addr_t   raddr1;
  reg_addr_t   raddr2;
  word_t       rdata1;
  word_t       rdata2;
  id_exe_reg_t id_exe;
  exe_wb_reg_t exe_wb;
  // Register write bundle
  logic        wen;
  reg_addr_t   waddr;
  word_t       wdata;

  reg_file i_reg_file (
    .clk     (clk),
    .reset_n (reset_n),
    .raddr1  (raddr1),
    .raddr2  (raddr2),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .wen     (wen),
    .waddr   (waddr),
    .wdata   (wdata)
  );

  inst_decode i_inst_decode (
    .clk        (clk),
    .reset_n    (reset_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .raddr1     (raddr1),
    .raddr2     (raddr2),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .id_exe     (id_exe)
  );

  alu_execute i_alu_execute (
    .clk     (clk),
    .reset_n (reset_n),
    .id_exe  (id_exe),
    .wen     (wen),
    .waddr   (waddr),
    .wdata   (wdata),
    .exe_wb  (exe_wb)
  );

  result_stage i_result_stage (
    .exe_wb         (exe_wb),
    .wen            (wen),
    .waddr          (waddr),
    .wdata          (wdata),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal)
  );

endmodule : alu_core_top

/* tb/alu_core_ref.svh */
// Reference model that the pipeline testbench includes inside its module body
`ifndef ALU_CORE_REF_SVH
`define ALU_CORE_REF_SVH

// Expected retire record and the cycle in which it must show up
typedef struct packed {
  word_t       pc;
  reg_addr_t   rd;
  word_t       data;
  logic        illegal;
  logic [31:0] due;
} retire_rec_t;

// Architectural registers as the ISA defines them
word_t shadow_regs [32] = '{default: '0};

// Integer arithmetic of OP and OP-IMM where alt is funct7 bit 5
function automatic word_t arith(input word_t a, input word_t b, input logic [2:0] f3,
                                input logic alt);
  word_t value;
  case (f3)
    3'b000:  value = alt ? a - b : a + b;
    3'b001:  value = a << b[4:0];
    3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  value = (a < b) ? 32'd1 : 32'd0;
    3'b100:  value = a ^ b;
    3'b101: begin
      if (alt) value = $signed(a) >>> b[4:0];
      else value = a >> b[4:0];
    end
    3'b110:  value = a | b;
    default: value = a & b;
  endcase
  return value;
endfunction

// Expected retire of one instruction and its update of the shadow registers
function automatic retire_rec_t predict_retire(input word_t instr, input word_t addr);
  retire_rec_t rec;
  word_t       imm_u;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        legal;
  imm_u  = {instr[31:12], 12'h000};
  f3     = instr[14:12];
  f7     = instr[31:25];
  rec    = '0;
  rec.pc = addr;
  rec.rd = instr[11:7];
  legal  = 1'b1;
  case (instr[6:0])
    OPC_OP: begin
      legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
      rec.data = arith(shadow_regs[instr[19:15]], shadow_regs[instr[24:20]], f3, f7[5]);
    end
    OPC_OP_IMM: begin
      if (f3 == 3'b001) legal = (f7 == 7'h00);
      if (f3 == 3'b101) legal = (f7 == 7'h00) || (f7 == 7'h20);
      rec.data = arith(shadow_regs[instr[19:15]], {{20{instr[31]}}, instr[31:20]}, f3,
                       (f3 == 3'b101) && f7[5]);
    end
    OPC_LUI:   rec.data = imm_u;
    OPC_AUIPC: rec.data = addr + imm_u;
    default:   legal = 1'b0;
  endcase
  rec.illegal = ~legal;
  if (!legal) rec.data = '0;
  else if (rec.rd != 5'd0) shadow_regs[rec.rd] = rec.data;
  return rec;
endfunction

`endif

/* tb/tb_alu_core.sv */
// Testbench for the RV32I pipeline top that runs as the simulation top
`timescale 1ns/1ps

module tb_alu_core;
  import riscv_types::*;

  localparam int DRAIN_LIMIT = 20;

  logic      clk = 1'b0;
  logic      reset_n;
  logic      inst_valid;
  word_t     inst;
  word_t     pc;
  logic      retire_valid;
  word_t     retire_pc;
  reg_addr_t retire_rd;
  word_t     retire_data;
  logic      retire_illegal;

  `include "alu_core_ref.svh"

  logic [31:0] cycle_cnt = '0;
  word_t       pc_cnt;
  int          checks = 0;
  int          errors = 0;
  int          test_checks;
  int          test_errors;
  retire_rec_t expect_q [$];
  retire_rec_t exp_rec;

  alu_core_top i_dut (
    .clk            (clk),
    .reset_n        (reset_n),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .pc             (pc),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

  function automatic word_t r_inst(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_inst(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic word_t u_inst(input logic [6:0] opc, input logic [19:0] imm,
                                   input reg_addr_t rd);
    return {imm, rd, opc};
  endfunction

  function automatic reg_addr_t pick_reg();
    return reg_addr_t'($urandom_range(31, 1));
  endfunction

  // Legal OP or OP-IMM with a random operation
  function automatic word_t random_alu(input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
    word_t      noise;
    word_t      instr;
    logic [2:0] f3;
    logic [6:0] f7;
    noise = $urandom();
    f3    = noise[2:0];
    f7    = (noise[3] && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00;
    if (noise[4]) instr = r_inst(f7, rs2, rs1, f3, rd);
    else if ((f3 == 3'b001) || (f3 == 3'b101)) instr = i_inst({f7, noise[9:5]}, rs1, f3, rd);
    else instr = i_inst(noise[31:20], rs1, f3, rd);
    return instr;
  endfunction

  // Unknown opcodes and bad funct7 values
  function automatic word_t random_illegal(input reg_addr_t rd);
    word_t noise;
    word_t instr;
    noise = $urandom();
    case (noise[1:0])
      2'd0:    instr = {noise[31:12], rd, 7'b0000011};
      2'd1:    instr = {noise[31:12], rd, 7'b1100011};
      2'd2:    instr = r_inst(7'h01, noise[24:20], noise[19:15], noise[14:12], rd);
      default: instr = i_inst({7'h30, noise[24:20]}, noise[19:15], 3'b101, rd);
    endcase
    return instr;
  endfunction

  function automatic void check_field(input string name, input word_t expv, input word_t got);
    assert (got == expv) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expv, got);
    end
  endfunction

  task automatic compare_retire(input retire_rec_t rec);
    checks++;
    assert (cycle_cnt == rec.due) else begin
      errors++;
      $display("retire for pc %h came in cycle %0d instead of cycle %0d",
               rec.pc, cycle_cnt, rec.due);
    end
    check_field("retire_pc", rec.pc, retire_pc);
    check_field("retire_rd", {27'b0, rec.rd}, {27'b0, retire_rd});
    check_field("retire_data", rec.data, retire_data);
    check_field("retire_illegal", {31'b0, rec.illegal}, {31'b0, retire_illegal});
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (expect_q.size() == 0) begin
      assert (!retire_valid) else begin
        errors++;
        $display("retire_valid high with no instruction outstanding, pc %h", retire_pc);
      end
    end else if (retire_valid) begin
      exp_rec = expect_q.pop_front();
      compare_retire(exp_rec);
    end else begin
      assert (cycle_cnt <= expect_q[0].due) else begin
        errors++;
        $display("no retire arrived for the instruction at pc %h", expect_q[0].pc);
        void'(expect_q.pop_front());
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic issue(input word_t instr);
    retire_rec_t rec;
    rec     = predict_retire(instr, pc_cnt);
    rec.due = cycle_cnt + 32'd2;
    expect_q.push_back(rec);
    inst_valid = 1'b1;
    inst       = instr;
    pc         = pc_cnt;
    pc_cnt     = pc_cnt + 32'd4;
    next_cycle();
    inst_valid = 1'b0;
  endtask

  task automatic load_reg(input reg_addr_t rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;
    issue(u_inst(OPC_LUI, upper[31:12], rd));
    issue(i_inst(value[11:0], rd, 3'b000, rd));
  endtask

  task automatic start_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while ((expect_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
      next_cycle();
      waited++;
    end
    if (expect_q.size() != 0) begin
      $display("timeout: no retire arrived within %0d cycles in test %s", DRAIN_LIMIT, name);
      $display("tests failed");
      $finish;
    end else begin
      repeat (2) next_cycle();
      $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
               errors - test_errors);
    end
  endtask

  initial begin
    word_t noise;
    void'($urandom(32'h8ff6_3c8c));
    reset_n    = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    pc_cnt     = 32'h0000_1000;

    // Reset and idle cycles
    start_test();
    repeat (10) next_cycle();
    reset_n = 1'b1;
    repeat (5) next_cycle();
    issue(r_inst(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
    issue(r_inst(7'h00, 5'd9, 5'd7, 3'b110, 5'd5));
    issue(r_inst(7'h00, 5'd12, 5'd31, 3'b011, 5'd3));
    finish_test("reset");

    start_test();
    for (int r = 1; r < 32; r++) load_reg(reg_addr_t'(r), $urandom());
    load_reg(5'd1, 32'h8000_0000);
    load_reg(5'd2, 32'h0000_0001);
    load_reg(5'd3, 32'hffff_ffff);
    issue(r_inst(7'h00, 5'd2, 5'd1, 3'b010, 5'd4));
    issue(r_inst(7'h00, 5'd2, 5'd1, 3'b011, 5'd4));
    issue(r_inst(7'h00, 5'd2, 5'd3, 3'b010, 5'd4));
    issue(r_inst(7'h00, 5'd2, 5'd3, 3'b011, 5'd4));
    issue(r_inst(7'h00, 5'd1, 5'd2, 3'b010, 5'd4));
    // Shift amount 37 uses only its low 5 bits
    load_reg(5'd5, 32'h0000_0025);
    load_reg(5'd6, 32'hf000_0ff0);
    issue(r_inst(7'h00, 5'd5, 5'd6, 3'b001, 5'd7));
    issue(r_inst(7'h00, 5'd5, 5'd6, 3'b101, 5'd7));
    issue(r_inst(7'h20, 5'd5, 5'd6, 3'b101, 5'd7));
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if ((alt == 0) || (f == 0) || (f == 5)) begin
          repeat (4) issue(r_inst(alt == 1 ? 7'h20 : 7'h00, pick_reg(), pick_reg(), 3'(f),
                                  pick_reg()));
        end
      end
    end
    finish_test("r_type");

    start_test();
    load_reg(5'd10, 32'h8765_4321);
    load_reg(5'd11, 32'h1234_5678);
    for (int f = 0; f < 8; f++) begin
      for (int src = 10; src < 12; src++) begin
        noise = $urandom();
        if (f == 1) begin
          issue(i_inst({7'h00, noise[4:0]}, reg_addr_t'(src), 3'(f), 5'd12));
        end else if (f == 5) begin
          issue(i_inst({7'h00, noise[4:0]}, reg_addr_t'(src), 3'(f), 5'd12));
          issue(i_inst({7'h20, noise[9:5]}, reg_addr_t'(src), 3'(f), 5'd13));
        end else begin
          issue(i_inst({1'b1, noise[10:0]}, reg_addr_t'(src), 3'(f), 5'd12));
          issue(i_inst({1'b0, noise[21:11]}, reg_addr_t'(src), 3'(f), 5'd13));
        end
      end
    end
    repeat (8) begin
      noise  = $urandom();
      pc_cnt = $urandom() & ~32'h3;
      issue(u_inst(OPC_AUIPC, noise[19:0], pick_reg()));
      issue(u_inst(OPC_LUI, noise[31:12], pick_reg()));
    end
    finish_test("i_type_lui_auipc");

    // Each instruction reads the results one and two ahead of it
    start_test();
    load_reg(5'd5, $urandom());
    load_reg(5'd6, $urandom());
    for (int i = 0; i < 200; i++) begin
      issue(random_alu(reg_addr_t'(5 + (i + 2) % 4), reg_addr_t'(5 + (i + 1) % 4),
                       reg_addr_t'(5 + i % 4)));
    end
    finish_test("back_to_back");

    start_test();
    load_reg(5'd1, 32'h0000_1000);
    issue(i_inst(12'h123, 5'd1, 3'b000, 5'd0));
    issue(r_inst(7'h00, 5'd0, 5'd0, 3'b000, 5'd5));
    issue(r_inst(7'h00, 5'd1, 5'd0, 3'b000, 5'd5));
    load_reg(5'd5, 32'h5555_aaaa);
    issue({12'h004, 5'd1, 3'b010, 5'd5, 7'b0000011});
    issue(r_inst(7'h01, 5'd2, 5'd1, 3'b000, 5'd5));
    issue(r_inst(7'h20, 5'd2, 5'd1, 3'b001, 5'd5));
    issue(i_inst({7'h20, 5'd3}, 5'd1, 3'b001, 5'd5));
    issue(i_inst({7'h10, 5'd3}, 5'd1, 3'b101, 5'd5));
    issue(i_inst(12'h000, 5'd5, 3'b000, 5'd6));
    finish_test("x0_illegal");

    start_test();
    for (int i = 0; i < 2000; i++) begin
      noise = $urandom();
      case (noise[3:0])
        4'd0, 4'd1: issue(random_illegal(pick_reg()));
        4'd2:       issue(u_inst(OPC_LUI, noise[31:12], pick_reg()));
        4'd3: begin
          pc_cnt = $urandom() & ~32'h3;
          issue(u_inst(OPC_AUIPC, noise[31:12], pick_reg()));
        end
        default:    issue(random_alu(reg_addr_t'(noise[8:4]), pick_reg(), pick_reg()));
      endcase
      repeat ($urandom_range(2, 0)) next_cycle();
    end
    finish_test("random_mix");

    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : tb_alu_core

/* files.f */
+incdir+tb
logic/riscv_types.sv
logic/reg_file.sv
logic/inst_decode.sv
logic/alu_execute.sv
logic/result_stage.sv
logic/alu_core_top.sv
tb/tb_alu_core.sv

/* Makefile */
# Verilator build and run of the pipeline testbench
VERILATOR ?= verilator
TOP       ?= tb_alu_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
